// ==== gfx_top.f ====
+incdir+verilog
verilog/gfx_bus_pkg.sv
verilog/gfx_pixel_pkg.sv
verilog/gfx_regs.sv
verilog/video_timing.sv
verilog/line_fetcher.sv
verilog/pixel_out.sv
verilog/gfx_top.sv
verification/gfx_chk.sv
verification/gfx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module gfx_tb -f gfx_top.f -o gfx_sim

./obj_dir/gfx_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== verification/gfx_chk.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"
`default_nettype none

module gfx_chk (
	input logic CLK,
	input logic reset,
	input logic mem_req,
	input logic mem_rvalid,
	input logic HS,
	input logic DE,
	input logic [3:0] RR,
	input logic [3:0] GG,
	input logic [3:0] BB
);

	logic [3:0] outstanding; // Requests without a returned word
	int fails = 0; // Assertion failures so far

	always_ff @(posedge CLK)
	begin
		if (reset)
			outstanding <= '0;
		else if (mem_req && !mem_rvalid)
			outstanding <= outstanding + 1'b1;
		else if (!mem_req && mem_rvalid)
			outstanding <= outstanding - 1'b1;
	end

	a_req_after_reset: assert property (@(posedge CLK) reset |=> !mem_req)
		else
		begin
			$error("memory request in the cycle after reset");
			fails++;
		end

	a_credit_limit: assert property (@(posedge CLK) disable iff (reset)
		outstanding <= `GFX_MEM_CREDITS)
		else
		begin
			$error("outstanding memory reads exceed the credit count");
			fails++;
		end

	a_blank: assert property (@(posedge CLK) disable iff (reset)
		!DE |-> (RR == 4'h0 && GG == 4'h0 && BB == 4'h0))
		else
		begin
			$error("colour output not blank outside DE");
			fails++;
		end

	a_hs_de: assert property (@(posedge CLK) disable iff (reset) !(!HS && DE))
		else
		begin
			$error("HS asserted while DE is high");
			fails++;
		end

endmodule

bind gfx_top gfx_chk chk0 (
	.CLK(CLK), .reset(reset), .mem_req(mem_req), .mem_rvalid(mem_rvalid),
	.HS(HS), .DE(DE), .RR(RR), .GG(GG), .BB(BB)
);

`default_nettype wire

// ==== verification/gfx_tb.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"
`default_nettype none

module gfx_tb
	import gfx_bus_pkg::*, gfx_pixel_pkg::*;
;
	localparam int HA = 16, HF = 2, HSY = 4, HB = 4;
	localparam int VA = 6, VF = 1, VSY = 2, VB = 1;
	localparam int HT = HA + HF + HSY + HB;
	localparam int FT = HT * (VA + VF + VSY + VB); // Cycles per frame
	localparam int LIMIT = 2000; // Six frames and the register tests

	logic CLK, reset, wr, mem_req, mem_rvalid, HS, VS, DE;
	logic [`GFX_ADDR_BITS-1:0] address;
	logic [15:0] data_in, data_out, mem_rdata;
	logic [`GFX_MEM_ADDR_BITS-1:0] mem_addr;
	logic [3:0] RR, GG, BB;

	logic [15:0] mem [65536]; // Image memory model
	logic [15:0] pend_addr [$];
	int pend_due [$];
	int mcyc, cycles, errors, checks, pos, dcount, win_pix, req_seen;
	int hs_len, de_len, vs_len, sync_runs, sync_err;
	bit pos_ok, prev_vs, chk_on;
	rgb_t pal_m [16];
	rgb_t bg_m;
	bit en_m;
	logic [13:0] base_m;

	gfx_top #(.H_ACTIVE(HA), .H_FRONT(HF), .H_SYNC(HSY), .H_BACK(HB),
		.V_ACTIVE(VA), .V_FRONT(VF), .V_SYNC(VSY), .V_BACK(VB)) dut0 (
		.CLK(CLK), .reset(reset), .wr(wr), .address(address), .data_in(data_in),
		.data_out(data_out), .mem_req(mem_req), .mem_addr(mem_addr),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .HS(HS), .VS(VS), .DE(DE),
		.RR(RR), .GG(GG), .BB(BB));

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic check_val(input string name, input int unsigned exp, input int unsigned act);
		checks++;
		assert (exp == act)
		else
		begin
			$display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	// Expected colour from memory layout, palette and fallback
	function automatic rgb_t model_pixel(input int x, input int y);
		logic [15:0] word;
		logic [3:0] idx;
		if (!en_m)
			return bg_m;
		word = mem[16'(base_m + y * (HA / 4) + x / 4)];
		idx = word[(x % 4) * 4 +: 4]; // Leftmost pixel in the low nibble
		return (idx == 4'h0) ? bg_m : pal_m[idx];
	endfunction

	// In-order memory with 1 to 4 cycles of latency
	always @(posedge CLK)
	begin
		if (reset)
		begin
			pend_addr.delete();
			pend_due.delete();
			mem_rvalid <= 1'b0;
		end
		else
		begin
			if (mem_req)
			begin
				pend_addr.push_back(mem_addr);
				pend_due.push_back(mcyc + 1 + int'($urandom_range(0, 3)));
			end
			if (pend_due.size() > 0 && pend_due[0] <= mcyc + 1)
			begin
				mem_rvalid <= 1'b1;
				mem_rdata <= mem[pend_addr.pop_front()];
				void'(pend_due.pop_front());
			end
			else
				mem_rvalid <= 1'b0;
		end
		mcyc++;
	end

	// Raster position, pixel compare and sync shape
	always @(negedge CLK)
	begin
		if (prev_vs && !VS)
		begin
			pos = (VA + VF) * HT + 2; // VS output trails the counters by two cycles
			pos_ok = 1'b1;
			dcount = 0;
		end
		else
			pos = (pos + 1) % FT;
		prev_vs = VS;
		if (chk_on && DE)
		begin
			check_val("RGB", model_pixel(dcount % HA, dcount / HA), {RR, GG, BB});
			win_pix++;
		end
		if (DE)
			dcount++;
		if (chk_on && mem_req)
			req_seen++;
		if (!reset)
		begin
			if (!HS)
				hs_len++;
			else if (hs_len != 0)
			begin
				check_val("HS low cycles", HSY, hs_len);
				sync_err += (hs_len != HSY);
				hs_len = 0;
				sync_runs++;
			end
			if (DE)
				de_len++;
			else if (de_len != 0)
			begin
				check_val("DE high cycles", HA, de_len);
				sync_err += (de_len != HA);
				de_len = 0;
			end
			if (!VS)
				vs_len++;
			else if (vs_len != 0)
			begin
				check_val("VS low cycles", VSY * HT, vs_len);
				sync_err += (vs_len != VSY * HT);
				vs_len = 0;
			end
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic write_reg(input logic [11:0] addr, input logic [15:0] data);
		wr <= 1'b1;
		address <= addr;
		data_in <= data;
		@(posedge CLK);
	endtask

	// One cycle of read latency
	task automatic read_reg(input logic [11:0] addr, output logic [15:0] value);
		address <= addr;
		@(posedge CLK);
		@(negedge CLK);
		value = data_out;
	endtask

	// Writes new state in vertical sync, then checks the frame after it
	task automatic frame_test(input string name, input bit en, input logic [13:0] base);
		int err0;
		err0 = errors;
		do @(posedge CLK); while (VS !== 1'b0);
		bg_m = rgb_t'($urandom);
		write_reg(REG_BG_COLOR, {4'h0, bg_m});
		for (int i = 0; i < 16; i++)
		begin
			pal_m[i] = rgb_t'($urandom);
			write_reg(REG_PALETTE_BASE + 12'(i), {4'h0, pal_m[i]});
		end
		en_m = en;
		base_m = base;
		write_reg(REG_LAYER_CTRL, {en, 1'b0, base});
		wr <= 1'b0;
		win_pix = 0;
		req_seen = 0;
		chk_on = 1'b1;
		do @(posedge CLK); while (VS !== 1'b1);
		do @(posedge CLK); while (VS !== 1'b0);
		chk_on = 1'b0;
		checks++;
		assert (win_pix == HA * VA)
		else
		begin
			$display("%s: %0d active pixels seen instead of %0d", name, win_pix, HA * VA);
			errors++;
		end
		if (!en)
			check_val("mem_req cycles", 0, req_seen);
		$display("test %s: %0d errors", name, errors - err0);
	endtask

	initial
	begin
		logic [15:0] a;
		logic [15:0] b;
		int exp_line;
		int err0;
		void'($urandom(32'hb1049e8b));
		for (int i = 0; i < 65536; i++)
			mem[i] = 16'($urandom);
		reset = 1'b1;
		wr = 1'b0;
		address = '0;
		data_in = '0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		repeat (3) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		check_val("HS", 1, HS);
		check_val("VS", 1, VS);
		check_val("DE", 0, DE);
		check_val("mem_req", 0, mem_req);
		@(posedge CLK);
		read_reg(REG_FRAME_COUNT, a);
		check_val("frame count", 0, a);
		$display("test reset: %0d errors", errors);

		err0 = errors;
		@(posedge CLK);
		read_reg(REG_FRAME_COUNT, a);
		check_val("frame count", 0, a);
		repeat (FT - 1) @(posedge CLK); // Second read exactly one frame later
		read_reg(REG_FRAME_COUNT, b);
		check_val("frame count step", 1, b);
		@(posedge CLK);
		address <= REG_LINE;
		@(posedge CLK);
		exp_line = ((pos + 1) % FT) / HT;
		@(negedge CLK);
		check_val("line", exp_line, data_out);
		checks++;
		assert (pos_ok)
		else
		begin
			$display("no VS edge seen before the line read");
			errors++;
		end
		$display("test read-back: %0d errors", errors - err0);

		frame_test("layer disabled", 1'b0, 14'h0);
		frame_test("layer enabled", 1'b1, 14'h0);
		frame_test("new base and palette", 1'b1, 14'($urandom));

		checks++;
		assert (sync_runs > 0)
		else
		begin
			$display("no complete HS pulse seen");
			errors++;
		end
		$display("test sync shape: %0d lines, %0d errors", sync_runs, sync_err);
		if (dut0.chk0.fails != 0)
		begin
			$display("%0d bound assertion failures", dut0.chk0.fails);
			errors += dut0.chk0.fails;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/gfx_bus_pkg.sv ====
`include "gfx_defs.svh"
`default_nettype none

package gfx_bus_pkg;

	localparam logic [`GFX_ADDR_BITS-1:0] REG_PALETTE_BASE = 12'hE00; // 16 entries
	localparam logic [`GFX_ADDR_BITS-1:0] REG_LAYER_CTRL = 12'hD00;
	localparam logic [`GFX_ADDR_BITS-1:0] REG_BG_COLOR = 12'hD01;
	localparam logic [`GFX_ADDR_BITS-1:0] REG_FRAME_COUNT = 12'hF00; // Read only
	localparam logic [`GFX_ADDR_BITS-1:0] REG_LINE = 12'hF01; // Read only

	localparam int LAYER_BASE_BITS = `GFX_DATA_BITS - 2;

	typedef struct packed {
		logic [3:0] unused;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} wdata_color_t;

	typedef struct packed {
		logic enable;
		logic unused;
		logic [LAYER_BASE_BITS-1:0] base; // Image base word address
	} wdata_ctrl_t;

	// Same CPU word, seen as a colour or as the layer control
	typedef union packed {
		wdata_color_t color;
		wdata_ctrl_t ctrl;
	} gfx_wdata_u;

endpackage

`default_nettype wire

// ==== verilog/gfx_defs.svh ====
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH
`default_nettype none

// Default 640x480 timing, pixels per line
`define GFX_H_ACTIVE 640
`define GFX_H_FRONT 16
`define GFX_H_SYNC 96
`define GFX_H_BACK 48

// Default vertical timing, lines per frame
`define GFX_V_ACTIVE 480
`define GFX_V_FRONT 10
`define GFX_V_SYNC 2
`define GFX_V_BACK 33

`define GFX_ADDR_BITS 12 // CPU register address
`define GFX_DATA_BITS 16 // CPU and memory word
`define GFX_MEM_ADDR_BITS 16 // Memory word address
`define GFX_MEM_CREDITS 4 // Outstanding memory reads
`define GFX_COUNT_BITS 10 // Raster counter width

`default_nettype wire
`endif

// ==== verilog/gfx_pixel_pkg.sv ====
`default_nettype none

package gfx_pixel_pkg;

	localparam int PAL_ENTRIES = 16;

	// 4:4:4 colour as it leaves the chip
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	typedef logic [$clog2(PAL_ENTRIES)-1:0] color_index_t; // Zero means background

endpackage

`default_nettype wire

// ==== verilog/gfx_regs.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"
`default_nettype none

module gfx_regs
	import gfx_bus_pkg::*, gfx_pixel_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic wr,
	input logic [`GFX_ADDR_BITS-1:0] address,
	input gfx_wdata_u data_in,
	input logic frame_start,
	input logic [`GFX_COUNT_BITS-1:0] v_count,
	output logic [`GFX_DATA_BITS-1:0] data_out,
	output logic pal_we,
	output color_index_t pal_index,
	output rgb_t pal_color,
	output rgb_t bg_color,
	output logic layer_enable,
	output logic [LAYER_BASE_BITS-1:0] layer_base
);

	logic [`GFX_ADDR_BITS-1:0] addr_q; // Read address, one cycle back
	logic [5:0] frame_count;
	logic pal_hit;
	rgb_t wr_color;

	assign pal_hit = address[`GFX_ADDR_BITS-1:4] == REG_PALETTE_BASE[`GFX_ADDR_BITS-1:4];

	// Colour view of the write word
	assign wr_color = '{red: data_in.color.red, green: data_in.color.green,
		blue: data_in.color.blue};

	// Palette RAM lives in the pixel stage
	assign pal_we = wr && pal_hit;
	assign pal_index = address[3:0];
	assign pal_color = wr_color;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			layer_enable <= 1'b0;
			layer_base <= '0;
			bg_color <= '0;
			frame_count <= '0;
			addr_q <= '0;
		end
		else
		begin
			if (wr && address == REG_LAYER_CTRL)
			begin
				layer_enable <= data_in.ctrl.enable; // Control view
				layer_base <= data_in.ctrl.base;
			end
			if (wr && address == REG_BG_COLOR)
				bg_color <= wr_color;
			if (frame_start)
				frame_count <= frame_count + 1'b1; // Wraps at 64
			addr_q <= address;
		end
	end

	// Read-back mux on the registered address
	always_comb
	begin
		case (addr_q)
			REG_FRAME_COUNT:
				data_out = `GFX_DATA_BITS'(frame_count);
			REG_LINE:
				data_out = `GFX_DATA_BITS'(v_count);
			default:
				data_out = '0; // Unmapped
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/gfx_top.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"
`default_nettype none

module gfx_top
	import gfx_bus_pkg::*, gfx_pixel_pkg::*;
#(
	parameter int H_ACTIVE = `GFX_H_ACTIVE,
	parameter int H_FRONT = `GFX_H_FRONT,
	parameter int H_SYNC = `GFX_H_SYNC,
	parameter int H_BACK = `GFX_H_BACK,
	parameter int V_ACTIVE = `GFX_V_ACTIVE,
	parameter int V_FRONT = `GFX_V_FRONT,
	parameter int V_SYNC = `GFX_V_SYNC,
	parameter int V_BACK = `GFX_V_BACK
) (
	input logic CLK,
	input logic reset,
	input logic wr,
	input logic [`GFX_ADDR_BITS-1:0] address,
	input gfx_wdata_u data_in,
	output logic [`GFX_DATA_BITS-1:0] data_out,
	output logic mem_req,
	output logic [`GFX_MEM_ADDR_BITS-1:0] mem_addr,
	input logic mem_rvalid,
	input logic [`GFX_DATA_BITS-1:0] mem_rdata,
	output logic HS,
	output logic VS,
	output logic DE,
	output logic [3:0] RR,
	output logic [3:0] GG,
	output logic [3:0] BB
);

	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	logic [`GFX_COUNT_BITS-1:0] h_count;
	logic [`GFX_COUNT_BITS-1:0] v_count;
	logic de;
	logic hsync;
	logic vsync;
	logic line_start;
	logic frame_start;
	logic pal_we;
	color_index_t pal_index;
	rgb_t pal_color;
	rgb_t bg_color;
	logic layer_enable;
	logic [LAYER_BASE_BITS-1:0] layer_base;
	color_index_t pix_index;

	gfx_regs regs0 (
		.CLK(CLK), .reset(reset), .wr(wr), .address(address), .data_in(data_in),
		.frame_start(frame_start), .v_count(v_count), .data_out(data_out),
		.pal_we(pal_we), .pal_index(pal_index), .pal_color(pal_color),
		.bg_color(bg_color), .layer_enable(layer_enable), .layer_base(layer_base)
	);

	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) vt0 (
		.CLK(CLK), .reset(reset), .h_count(h_count), .v_count(v_count), .de(de),
		.hsync(hsync), .vsync(vsync), .line_start(line_start), .frame_start(frame_start)
	);

	line_fetcher #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) lf0 (
		.CLK(CLK), .reset(reset), .line_start(line_start), .h_count(h_count),
		.v_count(v_count), .layer_enable(layer_enable), .layer_base(layer_base),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata), .pix_index(pix_index)
	);

	pixel_out po0 (
		.CLK(CLK), .reset(reset), .pix_index(pix_index), .pal_we(pal_we),
		.pal_index(pal_index), .pal_color(pal_color), .bg_color(bg_color),
		.de(de), .hsync(hsync), .vsync(vsync),
		.RR(RR), .GG(GG), .BB(BB), .HS(HS), .VS(VS), .DE(DE)
	);

endmodule

`default_nettype wire

// ==== verilog/line_fetcher.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"
`default_nettype none

module line_fetcher
	import gfx_bus_pkg::*, gfx_pixel_pkg::*;
#(
	parameter int H_ACTIVE = `GFX_H_ACTIVE,
	parameter int V_ACTIVE = `GFX_V_ACTIVE,
	parameter int V_TOTAL = `GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK
) (
	input logic CLK,
	input logic reset,
	input logic line_start,
	input logic [`GFX_COUNT_BITS-1:0] h_count,
	input logic [`GFX_COUNT_BITS-1:0] v_count,
	input logic layer_enable,
	input logic [LAYER_BASE_BITS-1:0] layer_base,
	output logic mem_req,
	output logic [`GFX_MEM_ADDR_BITS-1:0] mem_addr,
	input logic mem_rvalid,
	input logic [`GFX_DATA_BITS-1:0] mem_rdata,
	output color_index_t pix_index
);

	localparam int WORDS = H_ACTIVE / 4; // Four pixels per word
	localparam int WORD_BITS = $clog2(WORDS);
	localparam int CREDIT_BITS = $clog2(`GFX_MEM_CREDITS + 1);

	logic [`GFX_DATA_BITS-1:0] line_buf [2][WORDS]; // Halves by line parity
	logic [1:0] half_on; // Half holds a fetched line
	logic wr_half;
	logic req_active;
	logic [WORD_BITS-1:0] req_count;
	logic [WORD_BITS-1:0] ret_count;
	logic [CREDIT_BITS-1:0] credits;
	logic [`GFX_MEM_ADDR_BITS-1:0] line_addr;
	logic [`GFX_COUNT_BITS-1:0] next_line;
	logic fetch_start;
	logic rd_half;
	logic [WORD_BITS-1:0] rd_word;

	assign next_line = (v_count == `GFX_COUNT_BITS'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
	assign fetch_start = line_start && layer_enable && (next_line < V_ACTIVE);
	assign rd_half = v_count[0];
	assign rd_word = h_count[WORD_BITS+1:2];

	// No request without a credit in hand
	assign mem_req = req_active && (credits != '0);
	assign mem_addr = line_addr + `GFX_MEM_ADDR_BITS'(req_count);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			half_on <= 2'b00;
			wr_half <= 1'b0;
			req_active <= 1'b0;
			req_count <= '0;
			ret_count <= '0;
			credits <= CREDIT_BITS'(`GFX_MEM_CREDITS);
			line_addr <= '0;
		end
		else
		begin
			if (line_start)
			begin
				half_on[next_line[0]] <= fetch_start; // Disabled line shows index 0
				if (fetch_start)
				begin
					req_active <= 1'b1;
					req_count <= '0;
					ret_count <= '0;
					wr_half <= next_line[0];
					line_addr <= `GFX_MEM_ADDR_BITS'(layer_base)
						+ `GFX_MEM_ADDR_BITS'(next_line * WORDS);
				end
			end
			else
			begin
				if (mem_req)
				begin
					if (req_count == WORD_BITS'(WORDS - 1))
						req_active <= 1'b0; // Last word of the line
					req_count <= req_count + 1'b1;
				end
				if (mem_rvalid)
					ret_count <= ret_count + 1'b1;
			end

			// Spend on request, refund on return
			if (mem_req && !mem_rvalid)
				credits <= credits - 1'b1;
			else if (!mem_req && mem_rvalid)
				credits <= credits + 1'b1;
		end
	end

	// Returned words land in order
	always_ff @(posedge CLK)
	begin
		if (mem_rvalid)
			line_buf[wr_half][ret_count] <= mem_rdata;
	end

	// Leftmost pixel in the low nibble
	always_ff @(posedge CLK)
	begin
		if (reset)
			pix_index <= '0;
		else if (half_on[rd_half] && h_count < H_ACTIVE)
			pix_index <= line_buf[rd_half][rd_word][{h_count[1:0], 2'b00} +: 4];
		else
			pix_index <= '0;
	end

endmodule

`default_nettype wire

// ==== verilog/pixel_out.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_out
	import gfx_pixel_pkg::*;
(
	input logic CLK,
	input logic reset,
	input color_index_t pix_index,
	input logic pal_we,
	input color_index_t pal_index,
	input rgb_t pal_color,
	input rgb_t bg_color,
	input logic de,
	input logic hsync,
	input logic vsync,
	output logic [3:0] RR,
	output logic [3:0] GG,
	output logic [3:0] BB,
	output logic HS,
	output logic VS,
	output logic DE
);

	rgb_t palette [PAL_ENTRIES];
	rgb_t pal_q; // Registered palette read
	logic zero_q; // Index was 0 at lookup
	logic [1:0] de_d;
	logic [1:0] hs_d;
	logic [1:0] vs_d;
	rgb_t color;

	always_ff @(posedge CLK)
	begin
		if (pal_we)
			palette[pal_index] <= pal_color;
		pal_q <= palette[pix_index];
		zero_q <= pix_index == '0;
	end

	// Sync and enable follow the two-stage colour path
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			de_d <= 2'b00;
			hs_d <= 2'b11;
			vs_d <= 2'b11;
		end
		else
		begin
			de_d <= {de_d[0], de};
			hs_d <= {hs_d[0], hsync};
			vs_d <= {vs_d[0], vsync};
		end
	end

	assign color = zero_q ? bg_color : pal_q; // Background fallback

	assign DE = de_d[1];
	assign HS = hs_d[1];
	assign VS = vs_d[1];

	// Blank outside the display area
	assign RR = DE ? color.red : 4'h0;
	assign GG = DE ? color.green : 4'h0;
	assign BB = DE ? color.blue : 4'h0;

endmodule

`default_nettype wire

// ==== verilog/video_timing.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE = `GFX_H_ACTIVE,
	parameter int H_FRONT = `GFX_H_FRONT,
	parameter int H_SYNC = `GFX_H_SYNC,
	parameter int H_BACK = `GFX_H_BACK,
	parameter int V_ACTIVE = `GFX_V_ACTIVE,
	parameter int V_FRONT = `GFX_V_FRONT,
	parameter int V_SYNC = `GFX_V_SYNC,
	parameter int V_BACK = `GFX_V_BACK
) (
	input logic CLK,
	input logic reset,
	output logic [`GFX_COUNT_BITS-1:0] h_count,
	output logic [`GFX_COUNT_BITS-1:0] v_count,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic line_start,
	output logic frame_start
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int VS_START = V_ACTIVE + V_FRONT;

	logic [`GFX_COUNT_BITS-1:0] h_next;
	logic [`GFX_COUNT_BITS-1:0] v_next;

	always_comb
	begin
		h_next = h_count + 1'b1;
		v_next = v_count;
		if (h_count == `GFX_COUNT_BITS'(H_TOTAL - 1))
		begin
			h_next = '0;
			if (v_count == `GFX_COUNT_BITS'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = v_count + 1'b1;
		end
	end

	// Decode from the next count so outputs line up with the counters
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			h_count <= '0;
			v_count <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b1; // Counters rest on the first active pixel
			line_start <= 1'b0;
			frame_start <= 1'b0;
		end
		else
		begin
			h_count <= h_next;
			v_count <= v_next;
			hsync <= !(h_next >= HS_START && h_next < HS_START + H_SYNC); // Low active
			vsync <= !(v_next >= VS_START && v_next < VS_START + V_SYNC);
			de <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
			line_start <= h_next == '0;
			frame_start <= (h_next == '0) && (v_next == '0);
		end
	end

endmodule

`default_nettype wire
